//--- design/basic_ptr_init.sv
// ========================================
// BASIC pointer init
// Rewrites the zero page BASIC pointers
// after a PRG download, then starts RUN
// ========================================

`default_nettype none

`include "c64_loader_settings.svh"

module basic_ptr_init import c64_loader_pkg::*; (
	input  wire        clk_sys,
	input  wire        reset_n,
	input  wire        ioctl_download_i,
	input  wire [7:0]  ioctl_index_i,
	input  wire [15:0] prg_end_i,
	mem_wr_if.source   wr,
	output logic       run_start_o
);

	logic       dl_d;
	logic       active;
	logic       req_q;
	logic       run_q;
	logic [7:0] zp_addr;

	logic       ptr_hit;
	logic [7:0] ptr_data;
	logic       walk_done;
	logic       step;

	logic [7:0] wr_zp_q;
	logic [7:0] wr_data_q;

	// Values as BASIC LOAD would leave them
	always_comb begin
		ptr_hit  = 1'b1;
		ptr_data = 8'h00;
		case (zp_addr)
			// Program text start, same as after reset
			8'h2B: ptr_data = 8'h01;
			8'h2C: ptr_data = 8'h08;
			// Save start
			8'hAC, 8'hAD: ptr_data = 8'h00;
			// Variables, arrays, strings and load end all point past the program
			8'h2D, 8'h2F, 8'h31, 8'hAE: ptr_data = prg_end_i[7:0];
			8'h2E, 8'h30, 8'h32, 8'hAF: ptr_data = prg_end_i[15:8];
			default: ptr_hit = 1'b0;
		endcase
	end

	assign walk_done = (zp_addr > `PTR_LAST_ADDR);
	// One address per cycle while no write is outstanding
	assign step      = active && !wr.busy && !req_q;

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			dl_d    <= 1'b0;
			active  <= 1'b0;
			req_q   <= 1'b0;
			run_q   <= 1'b0;
			zp_addr <= `PTR_FIRST_ADDR;
		end else begin
			dl_d  <= ioctl_download_i;
			req_q <= 1'b0;
			run_q <= 1'b0;

			if (!active) begin
				if (dl_d && !ioctl_download_i && kind_of_index(ioctl_index_i) == KIND_PRG) begin
					active  <= 1'b1;
					zp_addr <= `PTR_FIRST_ADDR;
				end
			end else if (step) begin
				if (walk_done) begin
					// Last pointer write has left memory
					active <= 1'b0;
					run_q  <= 1'b1;
				end else begin
					zp_addr <= zp_addr + 1'b1;
					req_q   <= ptr_hit;
				end
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (step && !walk_done) begin
			wr_zp_q   <= zp_addr;
			wr_data_q <= ptr_data;
		end
	end

	assign wr.req      = req_q;
	assign wr.addr     = {{(`LOAD_ADDR_W-8){1'b0}}, wr_zp_q};
	assign wr.data     = wr_data_q;
	assign run_start_o = run_q;

endmodule

`default_nettype wire

//--- design/c64_loader.sv
// ========================================
// C64 loader top
// Host download to system memory path:
// image parser, BASIC pointer init and
// the slot writer
// ========================================

`default_nettype none

`include "c64_loader_settings.svh"

module c64_loader import c64_loader_pkg::*; (
	input  wire                     clk_sys,
	input  wire                     reset_n,
	// Host download port
	input  wire                     ioctl_download_i,
	input  wire [7:0]               ioctl_index_i,
	input  wire [`LOAD_ADDR_W-1:0]  ioctl_addr_i,
	input  wire [7:0]               ioctl_data_i,
	input  wire                     ioctl_wr_i,
	output logic                    ioctl_wait_o,
	// Memory slot port
	input  wire                     io_cycle_i,
	output logic                    mem_ce_o,
	output logic                    mem_we_o,
	output logic [`LOAD_ADDR_W-1:0] mem_addr_o,
	output logic [7:0]              mem_data_o,
	// Image info
	output logic [15:0]             prg_end_o,
	output logic [15:0]             cart_id_o,
	output logic [7:0]              cart_exrom_o,
	output logic [7:0]              cart_game_o,
	output logic [7:0]              cart_bank_type_o,
	output logic [15:0]             cart_bank_num_o,
	output logic [15:0]             cart_bank_laddr_o,
	output logic [15:0]             cart_bank_size_o,
	output logic                    cart_bank_wr_o,
	output logic                    cart_attached_o,
	output logic                    run_start_o
);

	cart_bank_t cart_bank;

	mem_wr_if prs_wr ();
	mem_wr_if ptr_wr ();

	image_parser image_parser_i (
		.clk_sys          (clk_sys),
		.reset_n          (reset_n),
		.ioctl_download_i (ioctl_download_i),
		.ioctl_index_i    (ioctl_index_i),
		.ioctl_addr_i     (ioctl_addr_i),
		.ioctl_data_i     (ioctl_data_i),
		.ioctl_wr_i       (ioctl_wr_i),
		.wr               (prs_wr.source),
		.prg_end_o        (prg_end_o),
		.cart_id_o        (cart_id_o),
		.cart_exrom_o     (cart_exrom_o),
		.cart_game_o      (cart_game_o),
		.cart_bank_o      (cart_bank),
		.cart_bank_wr_o   (cart_bank_wr_o),
		.cart_attached_o  (cart_attached_o)
	);

	basic_ptr_init basic_ptr_init_i (
		.clk_sys          (clk_sys),
		.reset_n          (reset_n),
		.ioctl_download_i (ioctl_download_i),
		.ioctl_index_i    (ioctl_index_i),
		.prg_end_i        (prg_end_o),
		.wr               (ptr_wr.source),
		.run_start_o      (run_start_o)
	);

	io_slot_writer io_slot_writer_i (
		.clk_sys    (clk_sys),
		.reset_n    (reset_n),
		.io_cycle_i (io_cycle_i),
		.prs        (prs_wr.sink),
		.ptr        (ptr_wr.sink),
		.mem_ce_o   (mem_ce_o),
		.mem_we_o   (mem_we_o),
		.mem_addr_o (mem_addr_o),
		.mem_data_o (mem_data_o)
	);

	// Host holds off while either source has a write in flight
	assign ioctl_wait_o = prs_wr.busy | ptr_wr.busy;

	assign cart_bank_type_o  = cart_bank.bank_type;
	assign cart_bank_num_o   = cart_bank.bank_num;
	assign cart_bank_laddr_o = cart_bank.laddr;
	assign cart_bank_size_o  = cart_bank.size;

endmodule

`default_nettype wire

//--- design/c64_loader_pkg.sv
// ========================================
// C64 loader package
// File kind decode and cartridge bank
// header layout
// ========================================

`default_nettype none

package c64_loader_pkg;

	// Kind of the file being downloaded
	typedef enum logic [1:0] {
		KIND_PRG   = 2'd0,
		KIND_CRT   = 2'd1,
		KIND_TAP   = 2'd2,
		KIND_OTHER = 2'd3
	} file_kind_e;

	// Bank fields of one CHIP packet, as sent to the cartridge logic
	typedef struct packed {
		logic [7:0]  bank_type;
		logic [15:0] bank_num;
		logic [15:0] laddr;
		logic [15:0] size;
	} cart_bank_t;

	// Map the host menu index to a file kind
	function automatic file_kind_e kind_of_index(input logic [7:0] index);
		file_kind_e kind;
		if (index[5:0] == 6'd4 && index[7:6] == 2'b00)
			kind = KIND_PRG;
		else if (index == 8'h05 || index == 8'hC0)
			kind = KIND_CRT;
		else if (index == 8'h06)
			kind = KIND_TAP;
		else
			kind = KIND_OTHER;
		return kind;
	endfunction

endpackage

`default_nettype wire

//--- design/c64_loader_settings.svh
// ========================================
// C64 loader settings
// Address width, memory bases for the
// cartridge and tape areas, and the zero
// page range of the BASIC pointers
// ========================================

`ifndef C64_LOADER_SETTINGS_SVH
`define C64_LOADER_SETTINGS_SVH

// Width of a system memory address
`define LOAD_ADDR_W 25

// Memory areas for downloaded images
`define CART_BASE 25'h100000
`define TAP_BASE 25'h200000

// CHIP packets start on an 8 KB boundary
`define CART_ALIGN_BITS 13
`define CRT_CHIP_START 25'h40

// Zero page span holding the BASIC pointers
`define PTR_FIRST_ADDR 8'h2B
`define PTR_LAST_ADDR 8'hAF

`endif

//--- design/image_parser.sv
// ========================================
// Image parser
// Turns the host byte stream of PRG, CRT
// and TAP files into memory write requests
// and captures the cartridge header fields
// ========================================

`default_nettype none

`include "c64_loader_settings.svh"

module image_parser import c64_loader_pkg::*; (
	input  wire                    clk_sys,
	input  wire                    reset_n,
	input  wire                    ioctl_download_i,
	input  wire [7:0]              ioctl_index_i,
	input  wire [`LOAD_ADDR_W-1:0] ioctl_addr_i,
	input  wire [7:0]              ioctl_data_i,
	input  wire                    ioctl_wr_i,
	mem_wr_if.source               wr,
	output logic [15:0]            prg_end_o,
	output logic [15:0]            cart_id_o,
	output logic [7:0]             cart_exrom_o,
	output logic [7:0]             cart_game_o,
	output cart_bank_t             cart_bank_o,
	output logic                   cart_bank_wr_o,
	output logic                   cart_attached_o
);

	file_kind_e              kind;
	logic                    strobe;
	logic                    chip_area;
	logic                    pkt_start;
	logic                    pkt_hdr;
	logic                    data_byte;
	logic [`LOAD_ADDR_W-1:0] cur_addr;

	logic                    dl_d;
	logic                    req_q;
	logic                    bank_wr_q;
	logic                    attached_q;
	logic [3:0]              hdr_cnt;
	logic [31:0]             blk_len;
	logic [`LOAD_ADDR_W-1:0] load_addr;

	logic [`LOAD_ADDR_W-1:0] wr_addr_q;
	logic [7:0]              wr_data_q;
	logic [15:0]             prg_end_q;
	logic [15:0]             cart_id_q;
	logic [7:0]              exrom_q;
	logic [7:0]              game_q;
	cart_bank_t              bank_q;

	// ========================================
	// Byte classification
	// ========================================
	assign kind      = kind_of_index(ioctl_index_i);
	assign strobe    = ioctl_download_i & ioctl_wr_i;
	assign chip_area = (kind == KIND_CRT) && (ioctl_addr_i >= `CRT_CHIP_START);
	// First byte of a CHIP packet, once the previous block is used up
	assign pkt_start = chip_area && (blk_len == '0) && (hdr_cnt == '0);
	assign pkt_hdr   = chip_area && (hdr_cnt != '0);

	always_comb begin
		case (kind)
			KIND_PRG: data_byte = (ioctl_addr_i > 'd1);
			KIND_CRT: data_byte = chip_area && !pkt_start && !pkt_hdr;
			KIND_TAP: data_byte = 1'b1;
			default:  data_byte = 1'b0;
		endcase
	end

	// Tape data starts at its base with the very first byte
	assign cur_addr = (kind == KIND_TAP && ioctl_addr_i == '0) ? `TAP_BASE : load_addr;

	// ========================================
	// Counters and strobes
	// ========================================
	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			dl_d       <= 1'b0;
			req_q      <= 1'b0;
			bank_wr_q  <= 1'b0;
			attached_q <= 1'b0;
			hdr_cnt    <= '0;
			blk_len    <= '0;
			load_addr  <= '0;
		end else begin
			dl_d      <= ioctl_download_i;
			req_q     <= strobe & data_byte;
			bank_wr_q <= strobe & pkt_hdr & (hdr_cnt == 4'd15);

			if (strobe) begin
				if (data_byte)
					load_addr <= cur_addr + 1'b1;

				if (kind == KIND_PRG) begin
					// Load address header, low byte first
					if (ioctl_addr_i == 'd0)
						load_addr <= {{(`LOAD_ADDR_W-8){1'b0}}, ioctl_data_i};
					if (ioctl_addr_i == 'd1)
						load_addr[15:8] <= ioctl_data_i;
				end

				if (kind == KIND_CRT) begin
					if (ioctl_addr_i == 'd0) begin
						load_addr <= `CART_BASE;
						blk_len   <= '0;
						hdr_cnt   <= '0;
					end

					if (pkt_start) begin
						hdr_cnt <= 4'd1;
						// Round up to the next 8 KB boundary
						if (load_addr[`CART_ALIGN_BITS-1:0] != '0) begin
							load_addr[`CART_ALIGN_BITS-1:0] <= '0;
							load_addr[`LOAD_ADDR_W-1:`CART_ALIGN_BITS] <=
								load_addr[`LOAD_ADDR_W-1:`CART_ALIGN_BITS] + 1'b1;
						end
					end else if (pkt_hdr) begin
						// Wraps to zero after byte 15
						hdr_cnt <= hdr_cnt + 1'b1;
						case (hdr_cnt)
							4'd4: blk_len[31:24] <= ioctl_data_i;
							4'd5: blk_len[23:16] <= ioctl_data_i;
							4'd6: blk_len[15:8]  <= ioctl_data_i;
							4'd7: blk_len[7:0]   <= ioctl_data_i;
							// Packet length includes its own 16 byte header
							4'd8: blk_len        <= blk_len - 32'd16;
							default: ;
						endcase
					end else if (data_byte) begin
						blk_len <= blk_len - 1'b1;
					end
				end
			end

			// Attached after a complete cartridge download, dropped when a new one starts
			if (kind == KIND_CRT && dl_d != ioctl_download_i)
				attached_q <= dl_d;
		end
	end

	// ========================================
	// Write payload and header fields
	// ========================================
	always_ff @(posedge clk_sys) begin
		if (strobe) begin
			if (data_byte) begin
				wr_addr_q <= cur_addr;
				wr_data_q <= ioctl_data_i;
			end

			if (kind == KIND_PRG) begin
				if (ioctl_addr_i == 'd0)
					prg_end_q[7:0] <= ioctl_data_i;
				else if (ioctl_addr_i == 'd1)
					prg_end_q[15:8] <= ioctl_data_i;
				else
					prg_end_q <= prg_end_q + 1'b1;
			end

			if (kind == KIND_CRT) begin
				// Cartridge id is stored big endian
				if (ioctl_addr_i == 'h16)
					cart_id_q[15:8] <= ioctl_data_i;
				if (ioctl_addr_i == 'h17)
					cart_id_q[7:0] <= ioctl_data_i;
				if (ioctl_addr_i == 'h18)
					exrom_q <= ioctl_data_i;
				if (ioctl_addr_i == 'h19)
					game_q <= ioctl_data_i;

				if (pkt_hdr) begin
					case (hdr_cnt)
						4'd9:  bank_q.bank_type      <= ioctl_data_i;
						4'd10: bank_q.bank_num[15:8] <= ioctl_data_i;
						4'd11: bank_q.bank_num[7:0]  <= ioctl_data_i;
						4'd12: bank_q.laddr[15:8]    <= ioctl_data_i;
						4'd13: bank_q.laddr[7:0]     <= ioctl_data_i;
						4'd14: bank_q.size[15:8]     <= ioctl_data_i;
						4'd15: bank_q.size[7:0]      <= ioctl_data_i;
						default: ;
					endcase
				end
			end
		end
	end

	assign wr.req          = req_q;
	assign wr.addr         = wr_addr_q;
	assign wr.data         = wr_data_q;
	assign prg_end_o       = prg_end_q;
	assign cart_id_o       = cart_id_q;
	assign cart_exrom_o    = exrom_q;
	assign cart_game_o     = game_q;
	assign cart_bank_o     = bank_q;
	assign cart_bank_wr_o  = bank_wr_q;
	assign cart_attached_o = attached_q;

endmodule

`default_nettype wire

//--- design/io_slot_writer.sv
// ========================================
// IO slot writer
// Holds one pending write and places it in
// the next free memory slot
// ========================================

`default_nettype none

`include "c64_loader_settings.svh"

module io_slot_writer (
	input  wire                     clk_sys,
	input  wire                     reset_n,
	input  wire                     io_cycle_i,
	mem_wr_if.sink                  prs,
	mem_wr_if.sink                  ptr,
	output logic                    mem_ce_o,
	output logic                    mem_we_o,
	output logic [`LOAD_ADDR_W-1:0] mem_addr_o,
	output logic [7:0]              mem_data_o
);

	logic                    io_d;
	logic                    pending;
	logic                    busy_q;
	logic                    src_ptr;
	logic                    ce_q;
	logic                    we_q;
	logic [`LOAD_ADDR_W-1:0] addr_q;
	logic [7:0]              data_q;

	logic                    slot_fall;
	logic                    slot_hold;
	logic                    take;

	// Slot opens as io_cycle falls, closes on its second high cycle
	assign slot_fall = !io_cycle_i && io_d;
	assign slot_hold = io_cycle_i && io_d;
	assign take      = ptr.req || prs.req;

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			io_d    <= 1'b0;
			pending <= 1'b0;
			busy_q  <= 1'b0;
			src_ptr <= 1'b0;
			ce_q    <= 1'b0;
			we_q    <= 1'b0;
		end else begin
			io_d <= io_cycle_i;

			if (take) begin
				pending <= 1'b1;
				busy_q  <= 1'b1;
				// Pointer sequencer wins a tie
				src_ptr <= ptr.req;
			end

			if (slot_fall && pending) begin
				pending <= 1'b0;
				ce_q    <= 1'b1;
				we_q    <= 1'b1;
			end

			if (slot_hold && we_q) begin
				ce_q   <= 1'b0;
				we_q   <= 1'b0;
				busy_q <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (take) begin
			addr_q <= ptr.req ? ptr.addr : prs.addr;
			data_q <= ptr.req ? ptr.data : prs.data;
		end
	end

	// Busy goes back only to the source that owns the write
	assign prs.busy   = busy_q && !src_ptr;
	assign ptr.busy   = busy_q && src_ptr;
	assign mem_ce_o   = ce_q;
	assign mem_we_o   = we_q;
	assign mem_addr_o = addr_q;
	assign mem_data_o = data_q;

endmodule

`default_nettype wire

//--- design/mem_wr_if.sv
// ========================================
// Memory write request interface
// One byte write from a request source to
// the slot writer, with busy back
// ========================================

`default_nettype none

`include "c64_loader_settings.svh"

interface mem_wr_if;

	logic                    req;
	logic [`LOAD_ADDR_W-1:0] addr;
	logic [7:0]              data;
	// High from the cycle after req until the memory pulse ends
	logic                    busy;

	modport source (output req, output addr, output data, input busy);
	modport sink (input req, input addr, input data, output busy);

endinterface

`default_nettype wire

//--- verif/c64_loader_tb.sv
// ========================================
// C64 loader testbench
// Downloads PRG, CRT and TAP files from a
// stimulus table and checks each memory
// write, the cartridge fields and RUN start
// ========================================

`default_nettype none

`include "c64_loader_settings.svh"

module c64_loader_tb;

	localparam int ROWS    = 5;
	localparam int ROW_PRG = 0;
	localparam int ROW_CRT = 1;
	localparam int ROW_TAP = 2;

	wire                     clk_sys;
	wire                     reset_n;
	logic                    ioctl_download;
	logic [7:0]              ioctl_index;
	logic [`LOAD_ADDR_W-1:0] ioctl_addr;
	logic [7:0]              ioctl_data;
	logic                    ioctl_wr;
	logic                    ioctl_wait;
	logic                    io_cycle;
	logic                    mem_ce;
	logic                    mem_we;
	logic [`LOAD_ADDR_W-1:0] mem_addr;
	logic [7:0]              mem_data;
	logic [15:0]             prg_end;
	logic [15:0]             cart_id;
	logic [7:0]              cart_exrom;
	logic [7:0]              cart_game;
	logic [7:0]              bank_type;
	logic [15:0]             bank_num;
	logic [15:0]             bank_laddr;
	logic [15:0]             bank_size;
	logic                    cart_bank_wr;
	logic                    cart_attached;
	logic                    run_start;

	// Stimulus table
	int row_kind [ROWS];
	int row_index [ROWS];
	int row_len [ROWS];
	int row_addr [ROWS];
	int row_pkts [ROWS];

	integer seed;
	integer slot_seed;
	int     slot_left;
	int     row;
	int     runs_before;
	int     total_bytes;
	int     cycle_limit = 2000;
	int     cycle_cnt = 0;
	int     run_count = 0;
	int     check_count = 0;
	int     mismatch_count = 0;
	int     other_count = 0;
	logic   we_seen = 1'b0;
	logic [1:0] io_hist = 2'b00;

	logic [7:0]              file_bytes [$];
	logic [`LOAD_ADDR_W-1:0] exp_addr [$];
	logic [7:0]              exp_data [$];
	logic [55:0]             exp_bank [$];
	logic [`LOAD_ADDR_W-1:0] cap_addr [$];
	logic [7:0]              cap_data [$];
	logic [55:0]             cap_bank [$];

	tb_clock_gen tb_clock_gen_i (
		.clk_sys_o (clk_sys),
		.reset_n_o (reset_n)
	);

	c64_loader c64_loader_i (
		.clk_sys           (clk_sys),
		.reset_n           (reset_n),
		.ioctl_download_i  (ioctl_download),
		.ioctl_index_i     (ioctl_index),
		.ioctl_addr_i      (ioctl_addr),
		.ioctl_data_i      (ioctl_data),
		.ioctl_wr_i        (ioctl_wr),
		.ioctl_wait_o      (ioctl_wait),
		.io_cycle_i        (io_cycle),
		.mem_ce_o          (mem_ce),
		.mem_we_o          (mem_we),
		.mem_addr_o        (mem_addr),
		.mem_data_o        (mem_data),
		.prg_end_o         (prg_end),
		.cart_id_o         (cart_id),
		.cart_exrom_o      (cart_exrom),
		.cart_game_o       (cart_game),
		.cart_bank_type_o  (bank_type),
		.cart_bank_num_o   (bank_num),
		.cart_bank_laddr_o (bank_laddr),
		.cart_bank_size_o  (bank_size),
		.cart_bank_wr_o    (cart_bank_wr),
		.cart_attached_o   (cart_attached),
		.run_start_o       (run_start)
	);

	// ========================================
	// Slot model and write capture
	// ========================================
	always @(negedge clk_sys) begin
		if (slot_left == 0) begin
			io_cycle = !io_cycle;
			// High for 2 to 4 cycles, low for 1 to 3
			if (io_cycle)
				slot_left = 1 + $unsigned($random(slot_seed)) % 3;
			else
				slot_left = $unsigned($random(slot_seed)) % 3;
		end else begin
			slot_left--;
		end
	end

	always @(posedge clk_sys) begin
		if (reset_n) begin
			if (mem_we && !we_seen) begin
				cap_addr.push_back(mem_addr);
				cap_data.push_back(mem_data);
				// io_hist[1] is two samples back, io_hist[0] the last one
				if (!(io_hist[1] && !io_hist[0])) begin
					other_count++;
					$display("Write at %0t started outside a free memory slot", $time);
				end
			end
			if (mem_we != mem_ce) begin
				mismatch_count++;
				$display("Mismatch at %0t: mem_ce_o got %0b expected %0b", $time, mem_ce, mem_we);
			end
			if (cart_bank_wr)
				cap_bank.push_back({bank_type, bank_num, bank_laddr, bank_size});
			if (run_start)
				run_count++;
		end
		we_seen <= mem_we;
		io_hist <= {io_hist[0], io_cycle};
	end

	always @(posedge clk_sys) begin
		cycle_cnt++;
		if (cycle_cnt > cycle_limit) begin
			other_count++;
			$display("Timeout: run did not finish within %0d cycles", cycle_limit);
			report_counts();
			$display("TEST FAILED");
			$finish;
		end
	end

	// ========================================
	// Helpers
	// ========================================
	task report_counts();
		$display("Checks: %0d, mismatches: %0d, other errors: %0d",
			check_count, mismatch_count, other_count);
	endtask

	task check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
		check_count++;
		if (got !== exp) begin
			mismatch_count++;
			$display("Mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
		end
	endtask

	task set_row(input int r, input int kind, input int index, input int len,
		input int addr, input int pkts);
		row_kind[r]  = kind;
		row_index[r] = index;
		row_len[r]   = len;
		row_addr[r]  = addr;
		row_pkts[r]  = pkts;
	endtask

	task expect_write(input logic [`LOAD_ADDR_W-1:0] addr, input logic [7:0] data);
		exp_addr.push_back(addr);
		exp_data.push_back(data);
	endtask

	task push_be16(input logic [15:0] word);
		file_bytes.push_back(word[15:8]);
		file_bytes.push_back(word[7:0]);
	endtask

	// Builds the file bytes of one row and the writes they must cause
	task build_file(input int r);
		logic [15:0] load;
		logic [15:0] end_addr;
		logic [15:0] size;
		logic [15:0] bank;
		logic [31:0] pkt_len;
		logic [7:0]  kind_byte;
		logic [7:0]  b;
		int          k;
		int          p;
		file_bytes.delete();
		exp_addr.delete();
		exp_data.delete();
		exp_bank.delete();
		cap_addr.delete();
		cap_data.delete();
		cap_bank.delete();
		if (row_kind[r] == ROW_PRG) begin
			load = row_addr[r];
			push_be16({load[7:0], load[15:8]});
			for (k = 0; k < row_len[r]; k++) begin
				b = $random(seed);
				file_bytes.push_back(b);
				expect_write(load + k, b);
			end
			// BASIC pointers, ascending zero page order
			end_addr = load + row_len[r];
			expect_write(8'h2B, 8'h01);
			expect_write(8'h2C, 8'h08);
			for (k = 0; k < 3; k++) begin
				expect_write(8'h2D + 2 * k, end_addr[7:0]);
				expect_write(8'h2E + 2 * k, end_addr[15:8]);
			end
			expect_write(8'hAC, 8'h00);
			expect_write(8'hAD, 8'h00);
			expect_write(8'hAE, end_addr[7:0]);
			expect_write(8'hAF, end_addr[15:8]);
		end else if (row_kind[r] == ROW_CRT) begin
			for (k = 0; k < `CRT_CHIP_START; k++) begin
				b = $random(seed);
				file_bytes.push_back(b);
			end
			for (p = 0; p < row_pkts[r]; p++) begin
				size      = 1 + $unsigned($random(seed)) % row_len[r];
				pkt_len   = size + 16;
				kind_byte = $random(seed);
				bank      = p;
				// CHIP signature, length, type, bank, load address, size
				push_be16(16'h4348);
				push_be16(16'h4950);
				push_be16(pkt_len[31:16]);
				push_be16(pkt_len[15:0]);
				push_be16({8'h00, kind_byte});
				push_be16(bank);
				push_be16(p[0] ? 16'hA000 : 16'h8000);
				push_be16(size);
				exp_bank.push_back({kind_byte, bank, (p[0] ? 16'hA000 : 16'h8000), size});
				for (k = 0; k < size; k++) begin
					b = $random(seed);
					file_bytes.push_back(b);
					expect_write(`CART_BASE + (p << `CART_ALIGN_BITS) + k, b);
				end
			end
		end else begin
			for (k = 0; k < row_len[r]; k++) begin
				b = $random(seed);
				file_bytes.push_back(b);
				expect_write(`TAP_BASE + k, b);
			end
		end
	endtask

	// ========================================
	// Host model
	// ========================================
	task send_byte(input int addr, input logic [7:0] data);
		while (ioctl_wait)
			@(negedge clk_sys);
		ioctl_addr = addr;
		ioctl_data = data;
		ioctl_wr   = 1'b1;
		@(negedge clk_sys);
		ioctl_wr = 1'b0;
		// Busy shows two cycles after the strobe
		@(negedge clk_sys);
		while (ioctl_wait)
			@(negedge clk_sys);
	endtask

	task download_file(input logic [7:0] index);
		int i;
		@(negedge clk_sys);
		ioctl_index    = index;
		ioctl_download = 1'b1;
		@(negedge clk_sys);
		for (i = 0; i < file_bytes.size(); i++)
			send_byte(i, file_bytes[i]);
		ioctl_download = 1'b0;
	endtask

	task check_row(input int r);
		logic [15:0] end_addr;
		int          i;
		end_addr = row_addr[r] + row_len[r];
		if (cap_addr.size() != exp_addr.size()) begin
			other_count++;
			$display("Row %0d: %0d memory writes seen, %0d expected",
				r, cap_addr.size(), exp_addr.size());
		end
		for (i = 0; i < cap_addr.size() && i < exp_addr.size(); i++) begin
			check_value("mem_addr_o", cap_addr[i], exp_addr[i]);
			check_value("mem_data_o", cap_data[i], exp_data[i]);
		end
		if (cap_bank.size() != exp_bank.size()) begin
			other_count++;
			$display("Row %0d: %0d bank pulses seen, %0d expected",
				r, cap_bank.size(), exp_bank.size());
		end
		for (i = 0; i < cap_bank.size() && i < exp_bank.size(); i++)
			check_value("cart_bank_type/num/laddr/size_o", cap_bank[i], exp_bank[i]);
		if (row_kind[r] == ROW_PRG)
			check_value("prg_end_o", prg_end, end_addr);
		if (row_kind[r] == ROW_CRT) begin
			check_value("cart_id_o", cart_id, {file_bytes[8'h16], file_bytes[8'h17]});
			check_value("cart_exrom_o", cart_exrom, file_bytes[8'h18]);
			check_value("cart_game_o", cart_game, file_bytes[8'h19]);
			check_value("cart_attached_o", cart_attached, 1'b1);
		end
		check_value("run_start_o pulses", run_count - runs_before,
			(row_kind[r] == ROW_PRG) ? 1 : 0);
	endtask

	// ========================================
	// Main sequence
	// ========================================
	initial begin
		seed           = 23;
		slot_seed      = seed + 1;
		slot_left      = 0;
		ioctl_download = 1'b0;
		ioctl_index    = 8'h00;
		ioctl_addr     = '0;
		ioctl_data     = 8'h00;
		ioctl_wr       = 1'b0;
		io_cycle       = 1'b0;

		// Kind, ioctl index, payload length, PRG load address, CHIP packets
		set_row(0, ROW_PRG, 8'h04, 40, 16'h0801, 0);
		set_row(1, ROW_CRT, 8'h05, 24, 0, 3);
		set_row(2, ROW_TAP, 8'h06, 48, 0, 0);
		set_row(3, ROW_CRT, 8'hC0, 12, 0, 2);
		set_row(4, ROW_PRG, 8'h04, 16, 16'hC000, 0);

		total_bytes = 0;
		for (row = 0; row < ROWS; row++) begin
			if (row_kind[row] == ROW_PRG)
				total_bytes += 2 + row_len[row];
			else if (row_kind[row] == ROW_CRT)
				total_bytes += `CRT_CHIP_START + row_pkts[row] * (16 + row_len[row]);
			else
				total_bytes += row_len[row];
		end
		cycle_limit = 40 * total_bytes + 2000;

		wait (reset_n);
		@(negedge clk_sys);
		check_value("mem_ce_o", mem_ce, 1'b0);
		check_value("mem_we_o", mem_we, 1'b0);
		check_value("ioctl_wait_o", ioctl_wait, 1'b0);
		check_value("cart_bank_wr_o", cart_bank_wr, 1'b0);
		check_value("run_start_o", run_start, 1'b0);
		check_value("cart_attached_o", cart_attached, 1'b0);

		for (row = 0; row < ROWS; row++) begin
			build_file(row);
			runs_before = run_count;
			download_file(row_index[row]);
			// A PRG download is complete once RUN has been started
			if (row_kind[row] == ROW_PRG) begin
				while (run_count == runs_before)
					@(negedge clk_sys);
			end
			repeat (8) @(negedge clk_sys);
			check_row(row);
		end

		report_counts();
		if (mismatch_count == 0 && other_count == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- verif/tb_clock_gen.sv
// ========================================
// Testbench clock and reset
// clk_sys with period 20, reset_n held
// low for the first 5 cycles
// ========================================

`default_nettype none

module tb_clock_gen (
	output logic clk_sys_o,
	output logic reset_n_o
);

	initial begin
		clk_sys_o = 1'b0;
		forever #10 clk_sys_o = !clk_sys_o;
	end

	// Released on a falling edge like every other input
	initial begin
		reset_n_o = 1'b0;
		repeat (5) @(posedge clk_sys_o);
		@(negedge clk_sys_o);
		reset_n_o = 1'b1;
	end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+design
design/c64_loader_pkg.sv
design/mem_wr_if.sv
design/image_parser.sv
design/basic_ptr_init.sv
design/io_slot_writer.sv
design/c64_loader.sv
verif/tb_clock_gen.sv
verif/c64_loader_tb.sv
